// File: vlog.f
+incdir+include
rtl/StoreDataPkg.sv
rtl/StoreDataLoad.sv
rtl/BankedRegFile.sv
rtl/StoreQueue.sv
rtl/StoreDataTop.sv
tests/StoreDataTb.sv

// File: Bender.yml
package:
  name: store_data

sources:
  - rtl/StoreDataPkg.sv
  - rtl/StoreDataLoad.sv
  - rtl/BankedRegFile.sv
  - rtl/StoreQueue.sv
  - rtl/StoreDataTop.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/StoreDataTb.sv

// File: include/StoreDataVectors.svh
`ifndef STORE_DATA_VECTORS_SVH
`define STORE_DATA_VECTORS_SVH

// Row holds rfWrite, alloc, both lane uops, both atomic inputs, branch and stall flag
// Expected stores hold storeSqN, data and offset in drain order
task automatic fillTable();
    // Immediates at every offset
    addRow(noWr, allocAt(6'd0), immOp(6'h05, 2'd0, 6'd0), noOp, noAmo, noAmo, noBr, 1'b0);
    addRow(noWr, allocAt(6'd1), noOp, immOp(6'h3E, 2'd1, 6'd1), noAmo, noAmo, noBr, 1'b0);
    addRow(noWr, allocAt(6'd2), immOp(6'h20, 2'd2, 6'd2), noOp, noAmo, noAmo, noBr, 1'b0);
    addRow(noWr, allocAt(6'd3), noOp, immOp(6'h1F, 2'd3, 6'd3), noAmo, noAmo, noBr, 1'b0);
    addRow(noWr, allocAt(6'd4), noOp, noOp, noAmo, noAmo, noBr, 1'b0);
    addRow(noWr, allocAt(6'd5), immOp(6'h3F, 2'd3, 6'd4), immOp(6'h01, 2'd2, 6'd5),
        noAmo, noAmo, noBr, 1'b0);

    // Register operands
    addRow(regWr(6'd4, 32'hA1B2C3D4), allocAt(6'd6), noOp, noOp, noAmo, noAmo, noBr, 1'b0);
    addRow(regWr(6'd7, 32'h11223344), allocAt(6'd7), regOp(6'd4, 2'd0, 6'd6), noOp,
        noAmo, noAmo, noBr, 1'b0);
    // Read of the bank that is being written
    addRow(regWr(6'd10, 32'h55667788), allocAt(6'd8), noOp, regOp(6'd10, 2'd1, 6'd7),
        noAmo, noAmo, noBr, 1'b0);
    addRow(noWr, allocAt(6'd9), regOp(6'd7, 2'd2, 6'd8), regOp(6'd10, 2'd3, 6'd9),
        noAmo, noAmo, noBr, 1'b0);

    // Atomic result overtakes the held micro-op on lane 0
    addRow(noWr, allocAt(6'd10), noOp, noOp, noAmo, noAmo, noBr, 1'b0);
    addRow(noWr, allocAt(6'd11), immOp(6'h07, 2'd0, 6'd11), noOp, noAmo, noAmo, noBr, 1'b0);
    addRow(noWr, allocAt(6'd12), immOp(6'h2A, 2'd1, 6'd12), noOp,
        amoOp(6'd10, 32'hDEADBEEF), noAmo, noBr, 1'b0);
    addRow(noWr, allocAt(6'd13), noOp, noOp, noAmo, noAmo, noBr, 1'b0);
    addRow(noWr, allocAt(6'd14), noOp, noOp, noAmo, amoOp(6'd13, 32'h0BADF00D), noBr, 1'b0);

    // Taken branch at 14 kills 15 and 16
    addRow(noWr, allocAt(6'd15), noOp, immOp(6'h03, 2'd0, 6'd15), noAmo, noAmo, noBr, 1'b0);
    addRow(noWr, allocAt(6'd16), immOp(6'h04, 2'd0, 6'd16), noOp, noAmo, noAmo, noBr, 1'b0);
    addRow(noWr, '0, immOp(6'h05, 2'd0, 6'd14), immOp(6'h09, 2'd0, 6'd16),
        noAmo, noAmo, branchAt(6'd14), 1'b0);
    addRow(noWr, '0, noOp, noOp, noAmo, noAmo, noBr, 1'b0);    // Head moves past 14
    addRow(noWr, '0, noOp, noOp, noAmo, noAmo, noBr, 1'b0);
    addRow(noWr, allocAt(6'd15), noOp, immOp(6'h06, 2'd0, 6'd15), noAmo, noAmo, noBr, 1'b0);
    addRow(noWr, allocAt(6'd16), noOp, noOp, noAmo, noAmo, noBr, 1'b0);
    // Flush lands while 16 and 17 write their data
    addRow(noWr, allocAt(6'd17), immOp(6'h11, 2'd0, 6'd17), immOp(6'h10, 2'd0, 6'd16),
        noAmo, noAmo, noBr, 1'b0);
    addRow(noWr, '0, noOp, noOp, noAmo, noAmo, flushBr, 1'b0);
    addRow(noWr, allocAt(6'd16), noOp, immOp(6'h12, 2'd0, 6'd16), noAmo, noAmo, noBr, 1'b0);
    addRow(noWr, allocAt(6'd17), immOp(6'h13, 2'd1, 6'd17), noOp, noAmo, noAmo, noBr, 1'b0);

    // Random storeReady stalls
    addRow(noWr, allocAt(6'd18), immOp(6'h21, 2'd1, 6'd18), noOp, noAmo, noAmo, noBr, 1'b1);
    addRow(noWr, allocAt(6'd19), noOp, regOp(6'd7, 2'd0, 6'd19), noAmo, noAmo, noBr, 1'b1);
    addRow(noWr, allocAt(6'd20), immOp(6'h0C, 2'd2, 6'd20), noOp, noAmo, noAmo, noBr, 1'b1);
    addRow(noWr, allocAt(6'd21), noOp, regOp(6'd4, 2'd3, 6'd21), noAmo, noAmo, noBr, 1'b1);
    addRow(regWr(6'd3, 32'hCAFEF00D), allocAt(6'd22), immOp(6'h3A, 2'd0, 6'd22), noOp,
        noAmo, noAmo, noBr, 1'b1);
    addRow(noWr, allocAt(6'd23), noOp, regOp(6'd10, 2'd1, 6'd23), noAmo, noAmo, noBr, 1'b1);
    addRow(noWr, allocAt(6'd24), regOp(6'd3, 2'd2, 6'd24), noOp, noAmo, noAmo, noBr, 1'b1);
    addRow(noWr, allocAt(6'd25), noOp, immOp(6'h1A, 2'd3, 6'd25), noAmo, noAmo, noBr, 1'b1);

    expectStore(6'd0, 32'h00000005, 2'd0);
    expectStore(6'd1, 32'hFFFFFE00, 2'd1);
    expectStore(6'd2, 32'hFFE00000, 2'd2);
    expectStore(6'd3, 32'h1F000000, 2'd3);
    expectStore(6'd4, 32'hFF000000, 2'd3);
    expectStore(6'd5, 32'h00010000, 2'd2);
    expectStore(6'd6, 32'hA1B2C3D4, 2'd0);
    expectStore(6'd7, 32'h66778800, 2'd1);
    expectStore(6'd8, 32'h33440000, 2'd2);
    expectStore(6'd9, 32'h88000000, 2'd3);
    expectStore(6'd10, 32'hDEADBEEF, 2'd0);
    expectStore(6'd11, 32'h00000007, 2'd0);
    expectStore(6'd12, 32'hFFFFEA00, 2'd1);
    expectStore(6'd13, 32'h0BADF00D, 2'd0);
    expectStore(6'd14, 32'h00000005, 2'd0);
    expectStore(6'd15, 32'h00000006, 2'd0);
    expectStore(6'd16, 32'h00000012, 2'd0);
    expectStore(6'd17, 32'h00001300, 2'd1);
    expectStore(6'd18, 32'hFFFFE100, 2'd1);
    expectStore(6'd19, 32'h11223344, 2'd0);
    expectStore(6'd20, 32'h000C0000, 2'd2);
    expectStore(6'd21, 32'hD4000000, 2'd3);
    expectStore(6'd22, 32'hFFFFFFFA, 2'd0);
    expectStore(6'd23, 32'h66778800, 2'd1);
    expectStore(6'd24, 32'hF00D0000, 2'd2);
    expectStore(6'd25, 32'h1A000000, 2'd3);
endtask

`endif

// File: tests/StoreDataTb.sv
module StoreDataTb
    import StoreDataPkg::*;
();

    localparam int width = 2;
    localparam int sqDepth = 16;
    localparam int period = 40;
    localparam int maxWait = 200;

    typedef struct packed {
        RfWrite wr;
        StDataUOp al;
        StDataLookupUOp [width-1:0] lane;
        AmoDataUOp [width-1:0] amo;
        BranchProv br;
        logic stall;                   // Random storeReady while set
    } VecRow;

    typedef struct packed {
        SqN storeSqN;
        RegT data;
        StOff_t offs;                  // Bytes below it are don't-care
    } ExpStore;

    localparam RfWrite noWr = '0;
    localparam StDataLookupUOp noOp = '0;
    localparam AmoDataUOp noAmo = '0;
    localparam BranchProv noBr = '0;
    localparam BranchProv flushBr = {1'b1, 1'b1, 6'd0};

    logic clk;
    logic rst;
    StDataLookupUOp uop [width-1:0];
    logic ready [width-1:0];
    AmoDataUOp atomicUop [width-1:0];
    BranchProv branch;
    RfWrite rfWrite;
    StDataUOp alloc;
    logic allocReady;
    StoreOut storeOut;
    logic storeReady;

    VecRow rows [$];
    ExpStore expected [$];
    logic stallMode;

    StoreDataTop #(
        .width(width),
        .sqDepth(sqDepth)
    ) uut (
        .clk(clk),
        .rst(rst),
        .uop(uop),
        .ready(ready),
        .atomicUop(atomicUop),
        .branch(branch),
        .rfWrite(rfWrite),
        .alloc(alloc),
        .allocReady(allocReady),
        .storeOut(storeOut),
        .storeReady(storeReady)
    );

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    function automatic RfWrite regWr(RFTag tag, RegT data);
        return {1'b1, tag, data};
    endfunction

    function automatic StDataUOp allocAt(SqN sqn);
        return {1'b1, sqn, 32'd0};
    endfunction

    function automatic StDataLookupUOp immOp(logic [5:0] val, StOff_t offs, SqN sqn);
        return {1'b1, 1'b1, val, offs, sqn};
    endfunction

    function automatic StDataLookupUOp regOp(RFTag tag, StOff_t offs, SqN sqn);
        return {1'b1, 1'b0, tag, offs, sqn};
    endfunction

    function automatic AmoDataUOp amoOp(SqN sqn, RegT result);
        return {1'b1, sqn, result};
    endfunction

    function automatic BranchProv branchAt(SqN sqn);
        return {1'b1, 1'b0, sqn};
    endfunction

    task automatic addRow(RfWrite wr, StDataUOp al, StDataLookupUOp lane0,
            StDataLookupUOp lane1, AmoDataUOp amo0, AmoDataUOp amo1, BranchProv br,
            logic stall);
        rows.push_back({wr, al, lane1, lane0, amo1, amo0, br, stall});
    endtask

    task automatic expectStore(SqN sqn, RegT data, StOff_t offs);
        expected.push_back({sqn, data, offs});
    endtask

    `include "StoreDataVectors.svh"

    task automatic failRun(string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic checkValue(string name, logic [31:0] got, logic [31:0] want);
        if (got !== want) begin
            failRun($sformatf("FAIL at %0t: %s = %h, expected %h", $time, name, got, want));
        end
    endtask

    task automatic setStoreReady();
        storeReady = stallMode ? 1'($urandom() % 2) : 1'b1;
    endtask

    task automatic driveRow(VecRow row);
        for (int i = 0; i < width; i++) begin
            uop[i] = row.lane[i];
            atomicUop[i] = row.amo[i];
        end
        rfWrite = row.wr;
        alloc = row.al;
        branch = row.br;
        stallMode = row.stall;
        setStoreReady();
    endtask

    // Inputs settle mid low phase, a transfer seen here happens at the next rising edge
    task automatic sampleCycle();
        ExpStore exp;
        RegT mask;
        #(period / 4);
        if (storeOut.valid && storeReady) begin
            if (expected.size() == 0) begin
                failRun($sformatf("Store %0d drained at %0t but none was expected",
                    storeOut.storeSqN, $time));
            end else begin
                exp = expected.pop_front();
                mask = 32'hFFFF_FFFF << (8 * exp.offs);
                checkValue("storeOut.storeSqN", 32'(storeOut.storeSqN), 32'(exp.storeSqN));
                checkValue("storeOut.data", storeOut.data & mask, exp.data & mask);
            end
        end
    endtask

    task automatic applyRow(VecRow row);
        logic accepted [width];
        logic allocTaken;
        logic pending;
        int waited;
        @(negedge clk);
        driveRow(row);
        pending = 1'b1;
        waited = 0;
        while (pending) begin
            if (waited == maxWait) begin
                failRun("Timed out waiting for a micro-op or allocation to be accepted");
            end else begin
                sampleCycle();
                allocTaken = allocReady;
                pending = alloc.valid && !allocReady;
                for (int i = 0; i < width; i++) begin
                    accepted[i] = ready[i];
                    pending = pending || (uop[i].valid && !ready[i]);
                end
                if (pending) begin
                    @(negedge clk);
                    rfWrite = '0;      // Writes, atomics and branches last one cycle
                    branch = '0;
                    alloc.valid = alloc.valid && !allocTaken;
                    for (int i = 0; i < width; i++) begin
                        atomicUop[i] = '0;
                        uop[i].valid = uop[i].valid && !accepted[i];
                    end
                    setStoreReady();
                    waited++;
                end
            end
        end
    endtask

    initial begin
        VecRow idle;
        int waited;
        void'($urandom(32'he43e));
        rst = 1'b1;
        rfWrite = '0;
        alloc = '0;
        branch = '0;
        storeReady = 1'b1;
        stallMode = 1'b0;
        for (int i = 0; i < width; i++) begin
            uop[i] = '0;
            atomicUop[i] = '0;
        end
        fillTable();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #(period / 4);
        checkValue("allocReady", allocReady, 1);
        checkValue("storeOut.valid", storeOut.valid, 0);
        checkValue("ready[0]", ready[0], 1);
        checkValue("ready[1]", ready[1], 1);

        foreach (rows[r]) begin
            applyRow(rows[r]);
        end

        // Keep random stalls going until every expected store is out
        idle = '0;
        idle.stall = 1'b1;
        @(negedge clk);
        driveRow(idle);
        waited = 0;
        while (expected.size() != 0) begin
            if (waited == maxWait) begin
                failRun("Timed out waiting for the store queue to drain");
            end else begin
                sampleCycle();
                @(negedge clk);
                setStoreReady();
                waited++;
            end
        end
        stallMode = 1'b0;
        setStoreReady();
        repeat (8) begin
            sampleCycle();     // Anything draining now is a stray
            @(negedge clk);
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: rtl/StoreDataTop.sv
module StoreDataTop
    import StoreDataPkg::*;
#(
    parameter int width = 2,
    parameter int sqDepth = 16
) (
    input  logic           clk,
    input  logic           rst,

    input  StDataLookupUOp uop [width-1:0],
    output logic           ready [width-1:0],
    input  AmoDataUOp      atomicUop [width-1:0],

    input  BranchProv      branch,
    input  RfWrite         rfWrite,

    input  StDataUOp       alloc,
    output logic           allocReady,

    output StoreOut        storeOut,
    input  logic           storeReady
);

    RfReadReq readReq [width-1:0];
    logic readReady [width-1:0];
    RegT readData [width-1:0];
    StDataUOp stData [width-1:0];

    StoreDataLoad #(
        .width(width)
    ) load (
        .clk(clk),
        .rst(rst),
        .branch(branch),
        .uop(uop),
        .ready(ready),
        .atomicUop(atomicUop),
        .readReq(readReq),
        .readReady(readReady),
        .readData(readData),
        .stData(stData)
    );

    BankedRegFile #(
        .width(width)
    ) regFile (
        .clk(clk),
        .rst(rst),
        .readReq(readReq),
        .readReady(readReady),
        .readData(readData),
        .rfWrite(rfWrite)
    );

    StoreQueue #(
        .width(width),
        .sqDepth(sqDepth)
    ) queue (
        .clk(clk),
        .rst(rst),
        .branch(branch),
        .alloc(alloc),
        .allocReady(allocReady),
        .stData(stData),
        .storeOut(storeOut),
        .storeReady(storeReady)
    );

endmodule

// File: rtl/StoreQueue.sv
module StoreQueue
    import StoreDataPkg::*;
#(
    parameter int width = 2,
    parameter int sqDepth = 16
) (
    input  logic      clk,
    input  logic      rst,

    input  BranchProv branch,

    input  StDataUOp  alloc,
    output logic      allocReady,

    input  StDataUOp  stData [width-1:0],

    output StoreOut   storeOut,
    input  logic      storeReady
);

    typedef logic [$clog2(sqDepth)-1:0] SqIdx;

    RegT entryData [sqDepth];
    logic [sqDepth-1:0] dataValid;

    SqN head;
    SqN tail;
    SqN count;
    SqN nextHead;
    SqN branchTail;
    SqN branchKeep;
    SqN liveAfter;
    logic drain;
    logic squashAll;

    // Entry sits between head and tail, unsigned distance handles the wrap
    function automatic logic inQueue(SqN sqn);
        SqN fromHead;
        fromHead = sqn - head;
        return fromHead < count;
    endfunction

    assign count = tail - head;
    assign allocReady = count != SqN'(sqDepth);

    assign storeOut.valid = count != '0 && dataValid[SqIdx'(head)];
    assign storeOut.storeSqN = head;
    assign storeOut.data = entryData[SqIdx'(head)];

    assign drain = storeOut.valid && storeReady;
    assign nextHead = head + SqN'(drain);

    assign branchTail = branch.storeSqN + 1'b1;
    assign branchKeep = branchTail - nextHead;
    assign liveAfter = tail - nextHead;
    assign squashAll = branch.flush || $signed(branchKeep) < 0;

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            dataValid <= '0;
        end else begin
            head <= nextHead;
            if (drain) begin
                dataValid[SqIdx'(head)] <= 1'b0;
            end

            if (alloc.valid && allocReady) begin
                tail <= alloc.storeSqN + 1'b1;
                dataValid[SqIdx'(alloc.storeSqN)] <= 1'b0;
            end

            for (int i = 0; i < width; i++) begin
                if (stData[i].valid && inQueue(stData[i].storeSqN)) begin
                    dataValid[SqIdx'(stData[i].storeSqN)] <= 1'b1;
                end
            end

            // Squash cuts the tail back, alloc in the same cycle is dropped
            if (branch.taken) begin
                if (squashAll) begin
                    tail <= nextHead;
                    dataValid <= '0;
                end else if (branchKeep < liveAfter) begin
                    tail <= branchTail;
                end
            end
        end
    end

    // Payload only, validity lives in dataValid
    always_ff @(posedge clk) begin
        for (int i = 0; i < width; i++) begin
            if (stData[i].valid && inQueue(stData[i].storeSqN)) begin
                entryData[SqIdx'(stData[i].storeSqN)] <= stData[i].data;
            end
        end
    end

endmodule

// File: rtl/BankedRegFile.sv
module BankedRegFile
    import StoreDataPkg::*;
#(
    parameter int width = 2
) (
    input  logic     clk,
    input  logic     rst,

    input  RfReadReq readReq [width-1:0],
    output logic     readReady [width-1:0],
    output RegT      readData [width-1:0],

    input  RfWrite   rfWrite
);

    localparam int numBanks = 2;
    localparam int bankDepth = 32;

    typedef logic [$clog2(bankDepth)-1:0] RowIdx;

    RegT regs [numBanks][bankDepth];

    logic writeBank;
    RowIdx writeRow;
    logic readBank [width-1:0];
    RowIdx readRow [width-1:0];

    // Low tag bit picks the bank, the rest the row
    assign writeBank = rfWrite.tag[0];
    assign writeRow = RowIdx'(rfWrite.tag >> 1);

    always_comb begin
        for (int i = 0; i < width; i++) begin
            readBank[i] = readReq[i].tag[0];
            readRow[i] = RowIdx'(readReq[i].tag >> 1);
        end
    end

    // The write port takes the read slot of its bank
    always_comb begin
        for (int i = 0; i < width; i++) begin
            readReady[i] = !(rfWrite.valid && writeBank == readBank[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int b = 0; b < numBanks; b++) begin
                for (int r = 0; r < bankDepth; r++) begin
                    regs[b][r] <= '0;
                end
            end
        end else if (rfWrite.valid) begin
            regs[writeBank][writeRow] <= rfWrite.data;
        end
    end

    // One registered read per lane
    always_ff @(posedge clk) begin
        for (int i = 0; i < width; i++) begin
            if (readReq[i].valid && readReady[i]) begin
                readData[i] <= regs[readBank[i]][readRow[i]];
            end
        end
    end

endmodule

// File: rtl/StoreDataLoad.sv
module StoreDataLoad
    import StoreDataPkg::*;
#(
    parameter int width = 2
) (
    input  logic           clk,
    input  logic           rst,

    input  BranchProv      branch,

    input  StDataLookupUOp uop [width-1:0],
    output logic           ready [width-1:0],
    input  AmoDataUOp      atomicUop [width-1:0],

    output RfReadReq       readReq [width-1:0],
    input  logic           readReady [width-1:0],
    input  RegT            readData [width-1:0],

    output StDataUOp       stData [width-1:0]
);

    // Moves the low bytes up by the offset, bytes below it end up zero
    function automatic RegT shiftData(RegT raw, StOff_t offs);
        return raw << {offs, 3'b000};
    endfunction

    function automatic RegT expandImm(Tag tag);
        return {{26{tag[5]}}, tag[5:0]};
    endfunction

    for (genvar i = 0; i < width; i++) begin : gLane
        StDataUOp held;
        logic lookup;              // Register data returns this cycle
        StOff_t lookupOffs;
        RegT lookupData;
        logic isImm;
        logic accept;
        RfReadReq req;
        StDataUOp out;

        assign isImm = uop[i].tag[$bits(Tag)-1];

        always_comb begin
            req.valid = uop[i].valid && !isImm;
            req.tag = RFTag'(uop[i].tag);
        end
        assign readReq[i] = req;

        // Stall while an atomic result occupies the lane or the bank is busy
        assign ready[i] = !(atomicUop[i].valid && held.valid) && (!req.valid || readReady[i]);

        assign accept = uop[i].valid && ready[i] && !branchKills(branch, uop[i].storeSqN);

        assign lookupData = shiftData(readData[i], lookupOffs);

        always_ff @(posedge clk) begin
            if (rst) begin
                held.valid <= 1'b0;
                lookup <= 1'b0;
            end else begin
                lookup <= 1'b0;

                // Keep the returned data in case the atomic input holds us up
                if (lookup) begin
                    held.data <= lookupData;
                end

                // Delivered unless an atomic result took the slot
                if (!atomicUop[i].valid || branchKills(branch, held.storeSqN)) begin
                    held.valid <= 1'b0;
                end

                if (accept) begin
                    held.valid <= 1'b1;
                    held.storeSqN <= uop[i].storeSqN;
                    if (isImm) begin
                        held.data <= shiftData(expandImm(uop[i].tag), uop[i].offs);
                    end else begin
                        lookup <= 1'b1;
                        lookupOffs <= uop[i].offs;
                    end
                end
            end
        end

        // Atomic result wins the lane
        always_comb begin
            out = '0;
            if (atomicUop[i].valid) begin
                out.valid = 1'b1;
                out.storeSqN = atomicUop[i].storeSqN;
                out.data = atomicUop[i].result;
            end else if (held.valid) begin
                out = held;
                if (lookup) begin
                    out.data = lookupData;   // Forward the fresh read
                end
            end
        end
        assign stData[i] = out;
    end

endmodule

// File: rtl/StoreDataPkg.sv
package StoreDataPkg;

    typedef logic [31:0] RegT;
    typedef logic [6:0] Tag;       // Top bit set: low 6 bits are a signed immediate
    typedef logic [5:0] RFTag;     // Bit 0 selects the bank
    typedef logic [1:0] StOff_t;
    typedef logic [5:0] SqN;       // Wraps, so ages are compared by difference

    typedef struct packed {
        logic valid;
        Tag tag;
        StOff_t offs;
        SqN storeSqN;
    } StDataLookupUOp;

    typedef struct packed {
        logic valid;
        SqN storeSqN;
        RegT result;
    } AmoDataUOp;

    // taken alone kills stores younger than storeSqN, flush kills all
    typedef struct packed {
        logic taken;
        logic flush;
        SqN storeSqN;
    } BranchProv;

    typedef struct packed {
        logic valid;
        RFTag tag;
    } RfReadReq;

    typedef struct packed {
        logic valid;
        RFTag tag;
        RegT data;
    } RfWrite;

    typedef struct packed {
        logic valid;
        SqN storeSqN;
        RegT data;
    } StDataUOp;

    typedef struct packed {
        logic valid;
        SqN storeSqN;
        RegT data;
    } StoreOut;

    function automatic logic isYounger(SqN sqn, SqN than);
        SqN diff;
        diff = sqn - than;
        return $signed(diff) > 0;
    endfunction

    function automatic logic branchKills(BranchProv br, SqN sqn);
        return br.taken && (br.flush || isYounger(sqn, br.storeSqN));
    endfunction

endpackage
